// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_core
RTL_TOP    := rv_core
FILE_LIST  := src.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
SOURCES    := $(wildcard src/*.sv verif/*.sv verif/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src.f ====
+incdir+verif
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/branch_unit.sv
src/rv_core.sv
verif/tb_rv_core.sv

// ==== src/alu.sv ====
// Arithmetic, logic, shift and compare unit of the integer core.
`timescale 1ns/10ps

module alu (
  input  rv_isa_pkg::word        a,
  input  rv_isa_pkg::word        b,
  input  core_ctrl_pkg::alu_op_t alu_op,
  input  logic                   sub_arith,
  output rv_isa_pkg::word        result
);

  logic [$clog2(rv_isa_pkg::xlen)-1:0] shamt;
  rv_isa_pkg::word                     sum;
  rv_isa_pkg::word                     shift_right;

  assign shamt = b[$clog2(rv_isa_pkg::xlen)-1:0];

  // sub_arith selects subtraction here and sign fill on the right shift.
  assign sum         = sub_arith ? (a - b) : (a + b);
  assign shift_right = sub_arith ? rv_isa_pkg::word'($signed(a) >>> shamt) : (a >> shamt);

  always_comb begin
    case (alu_op)
      core_ctrl_pkg::ALU_ADD:  result = sum;
      core_ctrl_pkg::ALU_SLL:  result = a << shamt;
      core_ctrl_pkg::ALU_SLT:  result = rv_isa_pkg::word'($signed(a) < $signed(b));
      core_ctrl_pkg::ALU_SLTU: result = rv_isa_pkg::word'(a < b);
      core_ctrl_pkg::ALU_XOR:  result = a ^ b;
      core_ctrl_pkg::ALU_SRL:  result = shift_right;
      core_ctrl_pkg::ALU_OR:   result = a | b;
      core_ctrl_pkg::ALU_AND:  result = a & b;
      default:                 result = sum;
    endcase
  end

endmodule

// ==== src/branch_unit.sv ====
// Branch condition evaluation on two register values.
`timescale 1ns/10ps

module branch_unit (
  input  rv_isa_pkg::word           rs1_data,
  input  rv_isa_pkg::word           rs2_data,
  input  core_ctrl_pkg::branch_op_t branch_op,
  output logic                      taken
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (branch_op)
      core_ctrl_pkg::BR_BEQ:  taken = eq;
      core_ctrl_pkg::BR_BNE:  taken = !eq;
      core_ctrl_pkg::BR_BLT:  taken = lt;
      core_ctrl_pkg::BR_BGE:  taken = !lt;
      core_ctrl_pkg::BR_BLTU: taken = ltu;
      core_ctrl_pkg::BR_BGEU: taken = !ltu;
      default:                taken = 1'b0;
    endcase
  end

endmodule

// ==== src/core_ctrl_pkg.sv ====
// Control-path definitions: datapath selects, ALU and branch operations, control bundle.
package core_ctrl_pkg;

  typedef enum logic [1:0] {
    PC_PLUS4,
    PC_ALU,
    PC_BRANCH
  } pc_mux_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC_PLUS4
  } wb_data_mux_t;

  typedef enum logic [1:0] {
    A_RS1,
    A_PC,
    A_ZERO
  } alu_a_mux_t;

  typedef enum logic {
    B_RS2,
    B_IMM
  } alu_b_mux_t;

  // encodings follow funct3 of the ALU instructions.
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SRL  = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } branch_op_t;

  typedef struct packed {
    pc_mux_t      pc_mux_sel;
    wb_data_mux_t wb_data_mux_sel;
    logic         wb_write_enable;
    alu_a_mux_t   alu_a_mux_sel;
    alu_b_mux_t   alu_b_mux_sel;
    alu_op_t      alu_op;
    logic         sub_arith;
    logic         dmem_write_enable;
    branch_op_t   branch_op;
  } ctrl_t;

  // an instruction that writes nothing and falls through to the next address.
  localparam ctrl_t ctrl_nop = '{
    pc_mux_sel:        PC_PLUS4,
    wb_data_mux_sel:   WB_ALU,
    wb_write_enable:   1'b0,
    alu_a_mux_sel:     A_RS1,
    alu_b_mux_sel:     B_IMM,
    alu_op:            ALU_ADD,
    sub_arith:         1'b0,
    dmem_write_enable: 1'b0,
    branch_op:         BR_BEQ
  };

endpackage

// ==== src/decoder.sv ====
// Instruction decoder turning an RV32I word into register indices, immediate and controls.
`timescale 1ns/10ps

module decoder (
  input  rv_isa_pkg::word      instr,
  output rv_isa_pkg::r         rs1,
  output rv_isa_pkg::r         rs2,
  output rv_isa_pkg::r         rd,
  output rv_isa_pkg::word      imm,
  output core_ctrl_pkg::ctrl_t ctrl
);

  rv_isa_pkg::opcode_t   opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_isa_pkg::word       imm_i;
  rv_isa_pkg::word       imm_s;
  rv_isa_pkg::word       imm_b;
  rv_isa_pkg::word       imm_u;
  rv_isa_pkg::word       imm_j;
  core_ctrl_pkg::alu_op_t alu_fn;
  logic                  alt_fn;

  assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct7 only selects the alternate form of add and right shift.
  assign alt_fn = (funct7 == rv_isa_pkg::f7_alt);

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_add:  alu_fn = core_ctrl_pkg::ALU_ADD;
      rv_isa_pkg::f3_sll:  alu_fn = core_ctrl_pkg::ALU_SLL;
      rv_isa_pkg::f3_slt:  alu_fn = core_ctrl_pkg::ALU_SLT;
      rv_isa_pkg::f3_sltu: alu_fn = core_ctrl_pkg::ALU_SLTU;
      rv_isa_pkg::f3_xor:  alu_fn = core_ctrl_pkg::ALU_XOR;
      rv_isa_pkg::f3_srl:  alu_fn = core_ctrl_pkg::ALU_SRL;
      rv_isa_pkg::f3_or:   alu_fn = core_ctrl_pkg::ALU_OR;
      default:             alu_fn = core_ctrl_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    ctrl = core_ctrl_pkg::ctrl_nop;
    imm  = imm_i;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        imm                  = imm_u;
        ctrl.alu_a_mux_sel   = core_ctrl_pkg::A_ZERO;
        ctrl.wb_write_enable = 1'b1;
      end
      rv_isa_pkg::OP_AUIPC: begin
        imm                  = imm_u;
        ctrl.alu_a_mux_sel   = core_ctrl_pkg::A_PC;
        ctrl.wb_write_enable = 1'b1;
      end
      rv_isa_pkg::OP_JAL: begin
        imm                  = imm_j;
        ctrl.pc_mux_sel      = core_ctrl_pkg::PC_ALU;
        ctrl.alu_a_mux_sel   = core_ctrl_pkg::A_PC;
        ctrl.wb_data_mux_sel = core_ctrl_pkg::WB_PC_PLUS4;
        ctrl.wb_write_enable = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        ctrl.pc_mux_sel      = core_ctrl_pkg::PC_ALU;
        ctrl.wb_data_mux_sel = core_ctrl_pkg::WB_PC_PLUS4;
        ctrl.wb_write_enable = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm                = imm_b;
        ctrl.alu_a_mux_sel = core_ctrl_pkg::A_PC;
        ctrl.pc_mux_sel    = core_ctrl_pkg::PC_BRANCH;
        case (funct3)
          rv_isa_pkg::f3_beq:  ctrl.branch_op = core_ctrl_pkg::BR_BEQ;
          rv_isa_pkg::f3_bne:  ctrl.branch_op = core_ctrl_pkg::BR_BNE;
          rv_isa_pkg::f3_blt:  ctrl.branch_op = core_ctrl_pkg::BR_BLT;
          rv_isa_pkg::f3_bge:  ctrl.branch_op = core_ctrl_pkg::BR_BGE;
          rv_isa_pkg::f3_bltu: ctrl.branch_op = core_ctrl_pkg::BR_BLTU;
          rv_isa_pkg::f3_bgeu: ctrl.branch_op = core_ctrl_pkg::BR_BGEU;
          // reserved conditions fall through like a no-operation.
          default:             ctrl.pc_mux_sel = core_ctrl_pkg::PC_PLUS4;
        endcase
      end
      rv_isa_pkg::OP_LOAD: begin
        // only word loads are decoded.
        if (funct3 == rv_isa_pkg::f3_word) begin
          ctrl.wb_data_mux_sel = core_ctrl_pkg::WB_MEM;
          ctrl.wb_write_enable = 1'b1;
        end
      end
      rv_isa_pkg::OP_STORE: begin
        imm = imm_s;
        if (funct3 == rv_isa_pkg::f3_word) begin
          ctrl.dmem_write_enable = 1'b1;
        end
      end
      rv_isa_pkg::OP_ALUI: begin
        ctrl.alu_op          = alu_fn;
        ctrl.sub_arith       = (funct3 == rv_isa_pkg::f3_srl) && alt_fn;
        ctrl.wb_write_enable = 1'b1;
      end
      rv_isa_pkg::OP_ALU: begin
        ctrl.alu_b_mux_sel   = core_ctrl_pkg::B_RS2;
        ctrl.alu_op          = alu_fn;
        ctrl.sub_arith       = ((funct3 == rv_isa_pkg::f3_add) ||
                                (funct3 == rv_isa_pkg::f3_srl)) && alt_fn;
        ctrl.wb_write_enable = 1'b1;
      end
      rv_isa_pkg::OP_FENCE, rv_isa_pkg::OP_CSR: begin
        ctrl = core_ctrl_pkg::ctrl_nop;
      end
      default: begin
        ctrl = core_ctrl_pkg::ctrl_nop;
      end
    endcase
  end

endmodule

// ==== src/reg_file.sv ====
// Integer register file with two combinational read ports and x0 tied to zero.
`timescale 1ns/10ps

module reg_file (
  input  logic            clk,
  input  logic            reset,
  input  rv_isa_pkg::r    rs1,
  input  rv_isa_pkg::r    rs2,
  input  rv_isa_pkg::r    rd,
  input  logic            wb_write_enable,
  input  rv_isa_pkg::word wb_data,
  output rv_isa_pkg::word rs1_data,
  output rv_isa_pkg::word rs2_data
);

  rv_isa_pkg::word regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write_enable && (rd != '0)) begin
      regs[rd] <= wb_data;
    end
  end

  // x0 has no storage and always reads as zero.
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_core.sv ====
// Single-cycle RV32I core with program counter, datapath muxes and execution units.
`timescale 1ns/10ps

module rv_core (
  input  logic            clk,
  input  logic            reset,
  output rv_isa_pkg::word imem_addr,
  input  rv_isa_pkg::word imem_data,
  output rv_isa_pkg::word dmem_addr,
  output rv_isa_pkg::word dmem_wdata,
  output logic            dmem_write_enable,
  input  rv_isa_pkg::word dmem_rdata
);

  rv_isa_pkg::word      pc;
  rv_isa_pkg::word      pc_plus4;
  rv_isa_pkg::word      next_pc;
  rv_isa_pkg::r         rs1;
  rv_isa_pkg::r         rs2;
  rv_isa_pkg::r         rd;
  rv_isa_pkg::word      imm;
  core_ctrl_pkg::ctrl_t ctrl;
  rv_isa_pkg::word      rs1_data;
  rv_isa_pkg::word      rs2_data;
  rv_isa_pkg::word      alu_a;
  rv_isa_pkg::word      alu_b;
  rv_isa_pkg::word      alu_result;
  rv_isa_pkg::word      wb_data;
  logic                 taken;

  decoder i_decoder (
    .instr (imem_data),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .imm   (imm),
    .ctrl  (ctrl)
  );

  reg_file i_reg_file (
    .clk             (clk),
    .reset           (reset),
    .rs1             (rs1),
    .rs2             (rs2),
    .rd              (rd),
    .wb_write_enable (ctrl.wb_write_enable),
    .wb_data         (wb_data),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data)
  );

  always_comb begin
    case (ctrl.alu_a_mux_sel)
      core_ctrl_pkg::A_PC:   alu_a = pc;
      core_ctrl_pkg::A_ZERO: alu_a = '0;
      default:               alu_a = rs1_data;
    endcase
  end

  assign alu_b = (ctrl.alu_b_mux_sel == core_ctrl_pkg::B_RS2) ? rs2_data : imm;

  alu i_alu (
    .a         (alu_a),
    .b         (alu_b),
    .alu_op    (ctrl.alu_op),
    .sub_arith (ctrl.sub_arith),
    .result    (alu_result)
  );

  branch_unit i_branch_unit (
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .branch_op (ctrl.branch_op),
    .taken     (taken)
  );

  assign pc_plus4 = pc + rv_isa_pkg::word'(4);

  always_comb begin
    case (ctrl.wb_data_mux_sel)
      core_ctrl_pkg::WB_MEM:      wb_data = dmem_rdata;
      core_ctrl_pkg::WB_PC_PLUS4: wb_data = pc_plus4;
      default:                    wb_data = alu_result;
    endcase
  end

  // JALR targets drop bit 0, which is already clear for JAL.
  always_comb begin
    case (ctrl.pc_mux_sel)
      core_ctrl_pkg::PC_ALU:    next_pc = {alu_result[rv_isa_pkg::xlen-1:1], 1'b0};
      core_ctrl_pkg::PC_BRANCH: next_pc = taken ? alu_result : pc_plus4;
      default:                  next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;

  // no store may reach memory while the core is held in reset.
  assign dmem_write_enable = ctrl.dmem_write_enable && !reset;

endmodule

// ==== src/rv_isa_pkg.sv ====
// RV32I instruction-set definitions: data types, major opcodes and function codes.
package rv_isa_pkg;

  localparam int xlen = 32;

  // data, address and instruction values all share the machine word.
  typedef logic [xlen-1:0] word;
  typedef logic [4:0] r;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_ALUI   = 7'b0010011,
    OP_ALU    = 7'b0110011,
    OP_FENCE  = 7'b0001111,
    OP_CSR    = 7'b1110011
  } opcode_t;

  // branch conditions in funct3.
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // arithmetic and logic functions in funct3.
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // word access width, the only one the core supports.
  localparam logic [2:0] f3_word = 3'b010;

  // funct7 for SUB and SRA.
  localparam logic [6:0] f7_alt = 7'b0100000;

endpackage

// ==== verif/tb_programs.svh ====
// Program builder that encodes RV32I instructions into the instruction memory image.
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic rv_isa_pkg::word r_type(logic [6:0] f7, rv_isa_pkg::r rs2,
                                           rv_isa_pkg::r rs1, logic [2:0] f3,
                                           rv_isa_pkg::r rd);
  return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_ALU};
endfunction

function automatic rv_isa_pkg::word i_type(logic [11:0] imm, rv_isa_pkg::r rs1,
                                           logic [2:0] f3, rv_isa_pkg::r rd,
                                           rv_isa_pkg::opcode_t op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_isa_pkg::word s_type(logic [11:0] imm, rv_isa_pkg::r rs2,
                                           rv_isa_pkg::r rs1);
  return {imm[11:5], rs2, rs1, rv_isa_pkg::f3_word, imm[4:0], rv_isa_pkg::OP_STORE};
endfunction

function automatic rv_isa_pkg::word b_type(logic [12:0] imm, rv_isa_pkg::r rs2,
                                           rv_isa_pkg::r rs1, logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
endfunction

function automatic rv_isa_pkg::word u_type(logic [19:0] imm, rv_isa_pkg::r rd,
                                           rv_isa_pkg::opcode_t op);
  return {imm, rd, op};
endfunction

function automatic rv_isa_pkg::word j_type(logic [20:0] imm, rv_isa_pkg::r rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
endfunction

// put places a word that the core is expected to jump over.
function automatic void put(rv_isa_pkg::word instr);
  imem[pc_emit[9:2]] = instr;
  pc_emit = pc_emit + 32'd4;
endfunction

function automatic void emit(rv_isa_pkg::word instr, logic we = 1'b0,
                             rv_isa_pkg::word addr = '0, rv_isa_pkg::word data = '0);
  trace.push_back(step_t'{pc_emit, we, addr, data});
  put(instr);
endfunction

`endif

// ==== verif/tb_rv_core.sv ====
// Testbench for the single-cycle RV32I core with memory models and a shadow register model.
`timescale 1ns/10ps

module tb_rv_core;

  // one executed instruction: its address and the store it must make, if any.
  typedef struct packed {
    rv_isa_pkg::word pc;
    logic            we;
    rv_isa_pkg::word addr;
    rv_isa_pkg::word data;
  } step_t;

  localparam rv_isa_pkg::word marker_addr = 32'h0000_03fc;
  localparam rv_isa_pkg::word nop = 32'h0000_0013;

  logic            clk = 1'b0;
  logic            reset;
  rv_isa_pkg::word imem_addr;
  rv_isa_pkg::word imem_data;
  rv_isa_pkg::word dmem_addr;
  rv_isa_pkg::word dmem_wdata;
  logic            dmem_write_enable;
  rv_isa_pkg::word dmem_rdata;

  rv_isa_pkg::word imem [256];
  rv_isa_pkg::word dmem [256];
  rv_isa_pkg::word shadow [32];
  step_t           trace [$];
  rv_isa_pkg::word pc_emit;
  rv_isa_pkg::word rng_state;
  int              next_slot;
  int              step = 0;
  int              cycles = 0;
  int              cycle_limit;

  `include "tb_programs.svh"

  rv_core i_rv_core (
    .clk               (clk),
    .reset             (reset),
    .imem_addr         (imem_addr),
    .imem_data         (imem_data),
    .dmem_addr         (dmem_addr),
    .dmem_wdata        (dmem_wdata),
    .dmem_write_enable (dmem_write_enable),
    .dmem_rdata        (dmem_rdata)
  );

  always #50 clk = ~clk;

  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_write_enable) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic rv_isa_pkg::word xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic rv_isa_pkg::word alu_ref(logic [2:0] f3, logic alt,
                                              rv_isa_pkg::word a, rv_isa_pkg::word b);
    case (f3)
      rv_isa_pkg::f3_add:  return alt ? a - b : a + b;
      rv_isa_pkg::f3_sll:  return a << b[4:0];
      rv_isa_pkg::f3_slt:  return {31'd0, $signed(a) < $signed(b)};
      rv_isa_pkg::f3_sltu: return {31'd0, a < b};
      rv_isa_pkg::f3_xor:  return a ^ b;
      rv_isa_pkg::f3_srl:  return alt ? rv_isa_pkg::word'($signed(a) >>> b[4:0]) : a >> b[4:0];
      rv_isa_pkg::f3_or:   return a | b;
      default:             return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, rv_isa_pkg::word a, rv_isa_pkg::word b);
    case (f3)
      rv_isa_pkg::f3_beq:  return a == b;
      rv_isa_pkg::f3_bne:  return a != b;
      rv_isa_pkg::f3_blt:  return $signed(a) < $signed(b);
      rv_isa_pkg::f3_bge:  return $signed(a) >= $signed(b);
      rv_isa_pkg::f3_bltu: return a < b;
      default:             return a >= b;
    endcase
  endfunction

  function automatic void write_reg(rv_isa_pkg::r rd, rv_isa_pkg::word value);
    if (rd != 5'd0) begin
      shadow[rd] = value;
    end
  endfunction

  // LUI takes the upper part rounded for the sign of the low 12 bits that ADDI adds.
  function automatic void load_const(rv_isa_pkg::r rd, rv_isa_pkg::word value);
    rv_isa_pkg::word upper;
    upper = value + 32'h0000_0800;
    emit(u_type(upper[31:12], rd, rv_isa_pkg::OP_LUI));
    emit(i_type(value[11:0], rd, rv_isa_pkg::f3_add, rd, rv_isa_pkg::OP_ALUI));
    write_reg(rd, value);
  endfunction

  function automatic void store_reg(rv_isa_pkg::r src);
    rv_isa_pkg::word addr;
    addr = rv_isa_pkg::word'(next_slot * 4);
    emit(s_type(addr[11:0], src, 5'd0), 1'b1, addr, shadow[src]);
    next_slot = (next_slot + 1) % 255;
  endfunction

  // the branch skips one filler word, so a taken branch lands 8 bytes ahead.
  function automatic void branch_over(logic [2:0] f3, rv_isa_pkg::r rs1, rv_isa_pkg::r rs2);
    emit(b_type(13'd8, rs2, rs1, f3));
    if (branch_ref(f3, shadow[rs1], shadow[rs2])) begin
      put(nop);
    end else begin
      emit(nop);
    end
  endfunction

  task automatic build_program();
    rv_isa_pkg::word a;
    rv_isa_pkg::word b;
    rv_isa_pkg::word base;
    logic [11:0]     imm12;
    logic [2:0]      f3;
    logic            alt;
    // the store at address 0 is fetched while reset is still high and must stay blocked.
    store_reg(5'd0);
    for (int f = 0; f < 16; f++) begin
      f3  = 3'(f % 8);
      alt = (f >= 8);
      if (!alt || f3 == rv_isa_pkg::f3_add || f3 == rv_isa_pkg::f3_srl) begin
        a = xorshift();
        b = xorshift();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(r_type(alt ? rv_isa_pkg::f7_alt : 7'd0, 5'd2, 5'd1, f3, 5'd3));
        write_reg(5'd3, alu_ref(f3, alt, a, b));
        store_reg(5'd3);
        // SUB has no immediate form. Shift immediates carry funct7 in their upper bits.
        if (!(alt && f3 == rv_isa_pkg::f3_add)) begin
          imm12 = b[11:0];
          if (f3 == rv_isa_pkg::f3_sll || f3 == rv_isa_pkg::f3_srl) begin
            imm12 = {alt ? rv_isa_pkg::f7_alt : 7'd0, b[4:0]};
          end
          emit(i_type(imm12, 5'd1, f3, 5'd4, rv_isa_pkg::OP_ALUI));
          write_reg(5'd4, alu_ref(f3, alt, a, {{20{imm12[11]}}, imm12}));
          store_reg(5'd4);
        end
      end
    end
    a = xorshift();
    load_const(5'd5, a);
    base = rv_isa_pkg::word'(next_slot * 4);
    store_reg(5'd5);
    emit(i_type(base[11:0], 5'd0, rv_isa_pkg::f3_word, 5'd6, rv_isa_pkg::OP_LOAD));
    write_reg(5'd6, a);
    emit(i_type(12'h123, 5'd6, rv_isa_pkg::f3_add, 5'd6, rv_isa_pkg::OP_ALUI));
    write_reg(5'd6, a + 32'h0000_0123);
    store_reg(5'd6);
    b = xorshift();
    emit(u_type(b[31:12], 5'd7, rv_isa_pkg::OP_LUI));
    write_reg(5'd7, {b[31:12], 12'd0});
    store_reg(5'd7);
    write_reg(5'd8, pc_emit + {b[31:12], 12'd0});
    emit(u_type(b[31:12], 5'd8, rv_isa_pkg::OP_AUIPC));
    store_reg(5'd8);
    emit(i_type(12'h7ff, 5'd1, rv_isa_pkg::f3_add, 5'd0, rv_isa_pkg::OP_ALUI));
    emit(u_type(b[31:12], 5'd0, rv_isa_pkg::OP_LUI));
    store_reg(5'd0);
    for (int f = 0; f < 8; f++) begin
      f3 = 3'(f);
      if (f3 != rv_isa_pkg::f3_slt && f3 != rv_isa_pkg::f3_sltu) begin
        load_const(5'd1, xorshift());
        load_const(5'd2, xorshift());
        emit(i_type(12'd0, 5'd1, rv_isa_pkg::f3_add, 5'd3, rv_isa_pkg::OP_ALUI));
        write_reg(5'd3, shadow[1]);
        branch_over(f3, 5'd1, 5'd3);
        branch_over(f3, 5'd1, 5'd2);
        branch_over(f3, 5'd2, 5'd1);
      end
    end
    base = pc_emit;
    emit(j_type(21'd8, 5'd10));
    write_reg(5'd10, base + 32'd4);
    put(nop);
    store_reg(5'd10);
    // JALR aims at an odd address one filler word past itself.
    base = pc_emit + 32'd8;
    emit(i_type(base[11:0], 5'd0, rv_isa_pkg::f3_add, 5'd11, rv_isa_pkg::OP_ALUI));
    write_reg(5'd11, base);
    emit(i_type(12'd5, 5'd11, 3'b000, 5'd12, rv_isa_pkg::OP_JALR));
    write_reg(5'd12, base);
    put(nop);
    store_reg(5'd12);
    emit({12'h0ff, 5'd0, 3'b000, 5'd1, rv_isa_pkg::OP_FENCE});
    emit(i_type(12'h300, 5'd2, 3'b001, 5'd1, rv_isa_pkg::OP_CSR));
    emit({20'h12345, 5'd1, 7'b1111111});
    store_reg(5'd1);
    store_reg(5'd2);
    emit(s_type(marker_addr[11:0], 5'd1, 5'd0), 1'b1, marker_addr, shadow[1]);
    cycle_limit = 2 * int'(pc_emit >> 2) + 50;
  endtask

  task automatic fail_with(string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
  endtask

  task automatic check_word(string name, rv_isa_pkg::word got, rv_isa_pkg::word expected);
    assert (got == expected) else begin
      fail_with($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, expected));
      $fatal(1);
    end
  endtask

  initial begin
    reset <= 1'b1;
    rng_state = 32'd75;
    pc_emit = '0;
    next_slot = 0;
    // unused words hold no-operations that differ by address.
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_type(12'(i), 5'd0, rv_isa_pkg::f3_add, 5'd0, rv_isa_pkg::OP_ALUI);
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    build_program();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      fail_with($sformatf("timeout: no final store after %0d cycles", cycles));
      $fatal(1);
    end
  end

  // outputs settle between edges, so they are sampled on the falling edge.
  always @(negedge clk) begin
    if (reset) begin
      check_word("imem_addr", imem_addr, '0);
      check_word("dmem_write_enable", {31'd0, dmem_write_enable}, '0);
    end else if (step >= trace.size()) begin
      fail_with("the core ran past the last instruction of the test program");
      $fatal(1);
    end else begin
      check_word("imem_addr", imem_addr, trace[step].pc);
      check_word("dmem_write_enable", {31'd0, dmem_write_enable}, {31'd0, trace[step].we});
      if (trace[step].we) begin
        check_word("dmem_addr", dmem_addr, trace[step].addr);
        check_word("dmem_wdata", dmem_wdata, trace[step].data);
      end
      step = step + 1;
      if (dmem_write_enable && dmem_addr == marker_addr) begin
        if (step == trace.size()) begin
          $display("Simulation PASSED");
          $finish;
        end else begin
          fail_with("the final store came before the end of the test program");
          $fatal(1);
        end
      end
    end
  end

endmodule
